// ==== design/naas_dma_pkg.sv ====
/* Buffer depth must stay a power of two. A descriptor is one qword, so a stored
   frame of n data qwords takes n+1 entries. */
package naas_dma_pkg;

    localparam int DATA_W           = 64;           // Stream and buffer word
    localparam int STRB_W           = DATA_W / 8;
    localparam int ADDR_W           = 6;
    localparam int BUF_DEPTH        = 2 ** ADDR_W;
    localparam int PTR_W            = ADDR_W + 1;   // Extra wrap bit, full vs empty
    localparam int MAX_BURST_QWORDS = 16;
    localparam int QCNT_W           = 5;            // Holds 0..16
    localparam int MAX_FRAME_QWORDS = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [QCNT_W-1:0] qcnt_t;

    // Descriptor qword placed ahead of every frame
    typedef struct packed {
        logic [47:0] reserved;
        logic [15:0] byte_count;
    } rx_desc_t;

    typedef union packed {
        logic [DATA_W-1:0] data;
        rx_desc_t          desc;
    } buf_entry_u;

endpackage

// ==== design/rx_buffer.sv ====
`timescale 1ns/1ns
/* Read data appears one rd_clk after rd_addr. No reset, contents are unknown until
   written. */
module rx_buffer (
    input  logic                     wr_clk,     // MAC side
    input  logic                     rd_clk,     // trn side
    input  logic                     wr_en,
    input  naas_dma_pkg::addr_t      wr_addr,
    input  naas_dma_pkg::buf_entry_u wr_data,
    input  naas_dma_pkg::addr_t      rd_addr,
    output naas_dma_pkg::buf_entry_u rd_data
);
    naas_dma_pkg::buf_entry_u mem [naas_dma_pkg::BUF_DEPTH];

    always_ff @(posedge wr_clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge rd_clk) begin
        rd_data <= mem[rd_addr];                 // Registered read port
    end

endmodule

// ==== design/rx_mac_interface.sv ====
`timescale 1ns/1ns
/* tstrb must be contiguous from bit 0 on the last beat. Frames over MAX_FRAME_QWORDS
   qwords are not supported. */
module rx_mac_interface (
    input  logic                            s_axis_aclk,
    input  logic                            arst_n,
    input  logic [naas_dma_pkg::DATA_W-1:0] s_axis_tdata,
    input  logic [naas_dma_pkg::STRB_W-1:0] s_axis_tstrb,
    input  logic                            s_axis_tvalid,
    input  logic                            s_axis_tlast,
    output logic                            s_axis_tready,
    output logic                            wr_en,
    output naas_dma_pkg::addr_t             wr_addr,
    output naas_dma_pkg::buf_entry_u        wr_data,
    output naas_dma_pkg::ptr_t              committed_wr_address,
    input  naas_dma_pkg::ptr_t              committed_rd_address_synch
);
    naas_dma_pkg::ptr_t wr_ptr;         // Next data slot
    naas_dma_pkg::ptr_t wr_ptr_sel;     // Slot written this cycle
    naas_dma_pkg::ptr_t used;
    logic [15:0]        byte_cnt;
    logic [15:0]        beat_bytes;
    logic [15:0]        desc_cnt;       // Byte count of the frame just closed
    logic               desc_pend;
    logic               beat;

    assign used          = wr_ptr - committed_rd_address_synch;  // Counts reserved desc slot
    assign s_axis_tready = !desc_pend && (used < naas_dma_pkg::ptr_t'(naas_dma_pkg::BUF_DEPTH));
    assign beat          = s_axis_tvalid && s_axis_tready;
    assign beat_bytes    = 16'($countones(s_axis_tstrb));

    // Descriptor write owns the port in the cycle after tlast
    assign wr_en      = desc_pend || beat;
    assign wr_ptr_sel = desc_pend ? committed_wr_address : wr_ptr;
    assign wr_addr    = wr_ptr_sel[naas_dma_pkg::ADDR_W-1:0];

    always_comb begin
        wr_data = '0;
        if (desc_pend)
            wr_data.desc.byte_count = desc_cnt;  // Reserved bits stay zero
        else
            wr_data.data = s_axis_tdata;
    end

    always_ff @(posedge s_axis_aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr               <= naas_dma_pkg::ptr_t'(1);  // Slot 0 held for 1st desc
            committed_wr_address <= '0;
            byte_cnt             <= '0;
            desc_pend            <= 1'b0;
        end else if (desc_pend) begin
            committed_wr_address <= wr_ptr;                   // Frame visible to trigger
            wr_ptr               <= wr_ptr + 1'b1;            // Reserve next desc slot
            desc_pend            <= 1'b0;
        end else if (beat) begin
            wr_ptr    <= wr_ptr + 1'b1;
            byte_cnt  <= s_axis_tlast ? 16'd0 : byte_cnt + beat_bytes;
            desc_pend <= s_axis_tlast;
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (beat && s_axis_tlast)
            desc_cnt <= byte_cnt + beat_bytes;
    end

    // Never overwrite entries the sender has not yet committed as read
    a_no_overwrite: assert property (@(posedge s_axis_aclk) disable iff (!arst_n)
        wr_en |-> (naas_dma_pkg::ptr_t'(wr_ptr_sel - committed_rd_address_synch)
                   < naas_dma_pkg::ptr_t'(naas_dma_pkg::BUF_DEPTH)));

    // Open frame plus its descriptor stays within the frame limit
    a_frame_len: assert property (@(posedge s_axis_aclk) disable iff (!arst_n)
        naas_dma_pkg::ptr_t'(wr_ptr - committed_wr_address)
            <= naas_dma_pkg::ptr_t'(naas_dma_pkg::MAX_FRAME_QWORDS + 1));

endmodule

// ==== design/rx_rd_addr_synch.sv ====
`timescale 1ns/1ns
/* Source pointer walks one step per trn_clk toward the input, so the Gray code
   changes one bit at a time. Jumps show up on the MAC side spread over cycles. */
module rx_rd_addr_synch (
    input  logic               s_axis_aclk,
    input  logic               trn_clk,
    input  logic               arst_n,
    input  naas_dma_pkg::ptr_t committed_rd_address,
    output naas_dma_pkg::ptr_t committed_rd_address_synch
);
    naas_dma_pkg::ptr_t src_bin;
    naas_dma_pkg::ptr_t gray_src;
    naas_dma_pkg::ptr_t sync_q1;
    naas_dma_pkg::ptr_t sync_q2;
    naas_dma_pkg::ptr_t bin;

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            src_bin  <= '0;
            gray_src <= '0;
        end else begin
            if (src_bin != committed_rd_address)
                src_bin <= src_bin + 1'b1;           // Single step
            gray_src <= src_bin ^ (src_bin >> 1);    // Bin to Gray
        end
    end

    always_comb begin
        for (int i = 0; i < naas_dma_pkg::PTR_W; i++)
            bin[i] = ^(sync_q2 >> i);                // Gray to bin
    end

    always_ff @(posedge s_axis_aclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1                    <= '0;
            sync_q2                    <= '0;
            committed_rd_address_synch <= '0;
        end else begin
            sync_q1                    <= gray_src;  // First sync stage
            sync_q2                    <= sync_q1;
            committed_rd_address_synch <= bin;       // Decode register
        end
    end

endmodule

// ==== design/rx_tlp_trigger.sv ====
`timescale 1ns/1ns
/* Only committed frames are sent. A new request waits until the previous ack has
   fully dropped. */
module rx_tlp_trigger (
    input  logic                s_axis_aclk,
    input  logic                arst_n,
    input  naas_dma_pkg::ptr_t  committed_wr_address,
    output logic                trigger_tlp,
    input  logic                trigger_tlp_ack_synch,
    output naas_dma_pkg::qcnt_t qwords_to_send
);
    naas_dma_pkg::ptr_t sent_ptr;      // End of data already handed to sender
    naas_dma_pkg::ptr_t pending;

    assign pending = committed_wr_address - sent_ptr;

    always_ff @(posedge s_axis_aclk or negedge arst_n) begin
        if (!arst_n) begin
            sent_ptr       <= '0;
            trigger_tlp    <= 1'b0;
            qwords_to_send <= '0;
        end else if (trigger_tlp && trigger_tlp_ack_synch) begin
            trigger_tlp <= 1'b0;                                    // Burst done
            sent_ptr    <= sent_ptr + naas_dma_pkg::ptr_t'(qwords_to_send);
        end else if (!trigger_tlp && !trigger_tlp_ack_synch && pending != '0) begin
            trigger_tlp <= 1'b1;
            if (pending > naas_dma_pkg::ptr_t'(naas_dma_pkg::MAX_BURST_QWORDS))
                qwords_to_send <= naas_dma_pkg::qcnt_t'(naas_dma_pkg::MAX_BURST_QWORDS);
            else
                qwords_to_send <= naas_dma_pkg::qcnt_t'(pending);  // Fits, at most 16
        end
    end

    // Count is captured on trn_clk while the request is up
    a_qwords_held: assert property (@(posedge s_axis_aclk) disable iff (!arst_n)
        trigger_tlp |->
            (qwords_to_send inside {[1:naas_dma_pkg::MAX_BURST_QWORDS]})
            && (!$past(trigger_tlp) || $stable(qwords_to_send)));

endmodule

// ==== design/rx_trigger_synch.sv ====
`timescale 1ns/1ns
/* qwords_to_send must hold still while trigger_tlp is high. It is sampled once on
   the trn_clk side when the request arrives. */
module rx_trigger_synch (
    input  logic                s_axis_aclk,
    input  logic                trn_clk,
    input  logic                arst_n,
    input  logic                trigger_tlp,
    input  naas_dma_pkg::qcnt_t qwords_to_send,
    output logic                trigger_tlp_synch,
    output naas_dma_pkg::qcnt_t qwords_to_send_synch,
    input  logic                trigger_tlp_ack,
    output logic                trigger_tlp_ack_synch
);
    logic req_q1;
    logic ack_q1;

    // Request into trn_clk
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q1            <= 1'b0;
            trigger_tlp_synch <= 1'b0;
        end else begin
            req_q1            <= trigger_tlp;
            trigger_tlp_synch <= req_q1;
        end
    end

    // Count lands on the same edge as the synced request
    always_ff @(posedge trn_clk) begin
        if (req_q1 && !trigger_tlp_synch)
            qwords_to_send_synch <= qwords_to_send;
    end

    // Ack back into s_axis_aclk
    always_ff @(posedge s_axis_aclk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q1                <= 1'b0;
            trigger_tlp_ack_synch <= 1'b0;
        end else begin
            ack_q1                <= trigger_tlp_ack;
            trigger_tlp_ack_synch <= ack_q1;
        end
    end

endmodule

// ==== design/rx_tlp_sender.sv ====
`timescale 1ns/1ns
/* host_tready may stall at any beat with no loss. The read pointer is committed only
   after the last qword of a burst has transferred. */
module rx_tlp_sender (
    input  logic                            trn_clk,
    input  logic                            arst_n,
    input  logic                            trigger_tlp_synch,
    input  naas_dma_pkg::qcnt_t             qwords_to_send_synch,
    output logic                            trigger_tlp_ack,
    output naas_dma_pkg::addr_t             rd_addr,
    input  naas_dma_pkg::buf_entry_u        rd_data,
    output naas_dma_pkg::ptr_t              committed_rd_address,
    output logic [naas_dma_pkg::DATA_W-1:0] host_tdata,
    output logic                            host_tvalid,
    output logic                            host_tlast,
    input  logic                            host_tready
);
    naas_dma_pkg::ptr_t             rd_ptr;         // Next qword to read
    naas_dma_pkg::qcnt_t            issue_left;
    logic                           busy;
    logic                           issue;
    logic                           pop;
    logic                           rd_vld_q;       // Read in flight
    logic                           rd_last_q;
    logic [naas_dma_pkg::DATA_W-1:0] skid_data [2];
    logic [1:0]                     skid_last;
    logic                           skid_wr_idx;
    logic                           skid_rd_idx;
    logic [1:0]                     skid_cnt;

    // ------------------------------------------------------------------------
    // Read issue and skid output
    // ------------------------------------------------------------------------
    assign rd_addr     = rd_ptr[naas_dma_pkg::ADDR_W-1:0];
    assign host_tvalid = (skid_cnt != 2'd0);
    assign host_tdata  = skid_data[skid_rd_idx];
    assign host_tlast  = skid_last[skid_rd_idx];
    assign pop         = host_tvalid && host_tready;
    // Skid must hold what is queued plus the read in flight
    assign issue = busy && (issue_left != '0)
                   && (3'(skid_cnt) + 3'(rd_vld_q) - 3'(pop) < 3'd2);

    always_ff @(posedge trn_clk) begin
        rd_last_q <= (issue_left == naas_dma_pkg::qcnt_t'(1));  // Last of burst
        if (rd_vld_q) begin
            skid_data[skid_wr_idx] <= rd_data.data;
            skid_last[skid_wr_idx] <= rd_last_q;
        end
    end

    // ------------------------------------------------------------------------
    // Burst control and handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy                 <= 1'b0;
            issue_left           <= '0;
            rd_ptr               <= '0;
            committed_rd_address <= '0;
            trigger_tlp_ack      <= 1'b0;
            rd_vld_q             <= 1'b0;
            skid_wr_idx          <= 1'b0;
            skid_rd_idx          <= 1'b0;
            skid_cnt             <= '0;
        end else begin
            rd_vld_q <= issue;
            skid_cnt <= skid_cnt + 2'(rd_vld_q) - 2'(pop);
            if (rd_vld_q)
                skid_wr_idx <= !skid_wr_idx;
            if (pop)
                skid_rd_idx <= !skid_rd_idx;
            if (issue)
                rd_ptr <= rd_ptr + 1'b1;

            if (trigger_tlp_synch && !busy && !trigger_tlp_ack) begin
                busy       <= 1'b1;                     // New burst
                issue_left <= qwords_to_send_synch;
            end else if (issue) begin
                issue_left <= issue_left - 1'b1;
            end

            if (pop && host_tlast) begin
                busy                 <= 1'b0;
                committed_rd_address <= rd_ptr;         // All burst reads issued
                trigger_tlp_ack      <= 1'b1;
            end else if (trigger_tlp_ack && !trigger_tlp_synch) begin
                trigger_tlp_ack      <= 1'b0;           // Four-phase return
            end
        end
    end

    a_host_stable: assert property (@(posedge trn_clk) disable iff (!arst_n)
        host_tvalid && !host_tready |=>
            host_tvalid && $stable(host_tdata) && $stable(host_tlast));

endmodule

// ==== design/naas_dma.sv ====
`timescale 1ns/1ns
/* arst_n resets both clock domains directly. Its release must be quiet relative to
   s_axis_aclk and trn_clk. */
module naas_dma (
    input  logic                            s_axis_aclk,     // MAC clock
    input  logic                            trn_clk,         // Host side clock
    input  logic                            arst_n,
    input  logic [naas_dma_pkg::DATA_W-1:0] s_axis_tdata,
    input  logic [naas_dma_pkg::STRB_W-1:0] s_axis_tstrb,
    input  logic                            s_axis_tvalid,
    input  logic                            s_axis_tlast,
    output logic                            s_axis_tready,
    output logic [naas_dma_pkg::DATA_W-1:0] host_tdata,
    output logic                            host_tvalid,
    output logic                            host_tlast,
    input  logic                            host_tready
);
    // ------------------------------------------------------------------------
    // Receive path wires
    // ------------------------------------------------------------------------
    logic                     rx_wr_en;
    naas_dma_pkg::addr_t      rx_wr_addr;
    naas_dma_pkg::buf_entry_u rx_wr_data;
    naas_dma_pkg::addr_t      rx_rd_addr;
    naas_dma_pkg::buf_entry_u rx_rd_data;
    naas_dma_pkg::ptr_t       rx_committed_wr_address;
    naas_dma_pkg::ptr_t       rx_committed_rd_address;        // trn_clk
    naas_dma_pkg::ptr_t       rx_committed_rd_address_synch;  // s_axis_aclk
    logic                     rx_trigger_tlp;
    logic                     rx_trigger_tlp_synch;
    logic                     rx_trigger_tlp_ack;
    logic                     rx_trigger_tlp_ack_synch;
    naas_dma_pkg::qcnt_t      rx_qwords_to_send;
    naas_dma_pkg::qcnt_t      rx_qwords_to_send_synch;

    rx_buffer rx_buffer_mod (
        .wr_clk(s_axis_aclk), .rd_clk(trn_clk), .wr_en(rx_wr_en),
        .wr_addr(rx_wr_addr), .wr_data(rx_wr_data),
        .rd_addr(rx_rd_addr), .rd_data(rx_rd_data));

    rx_mac_interface rx_mac_interface_mod (
        .s_axis_aclk, .arst_n, .s_axis_tdata, .s_axis_tstrb,
        .s_axis_tvalid, .s_axis_tlast, .s_axis_tready,
        .wr_en(rx_wr_en), .wr_addr(rx_wr_addr), .wr_data(rx_wr_data),
        .committed_wr_address(rx_committed_wr_address),
        .committed_rd_address_synch(rx_committed_rd_address_synch));

    rx_rd_addr_synch rx_rd_addr_synch_mod (
        .s_axis_aclk, .trn_clk, .arst_n,
        .committed_rd_address(rx_committed_rd_address),
        .committed_rd_address_synch(rx_committed_rd_address_synch));

    rx_tlp_trigger rx_tlp_trigger_mod (
        .s_axis_aclk, .arst_n,
        .committed_wr_address(rx_committed_wr_address),
        .trigger_tlp(rx_trigger_tlp),
        .trigger_tlp_ack_synch(rx_trigger_tlp_ack_synch),
        .qwords_to_send(rx_qwords_to_send));

    rx_trigger_synch rx_trigger_synch_mod (
        .s_axis_aclk, .trn_clk, .arst_n,
        .trigger_tlp(rx_trigger_tlp), .qwords_to_send(rx_qwords_to_send),
        .trigger_tlp_synch(rx_trigger_tlp_synch),
        .qwords_to_send_synch(rx_qwords_to_send_synch),
        .trigger_tlp_ack(rx_trigger_tlp_ack),
        .trigger_tlp_ack_synch(rx_trigger_tlp_ack_synch));

    rx_tlp_sender rx_tlp_sender_mod (
        .trn_clk, .arst_n,
        .trigger_tlp_synch(rx_trigger_tlp_synch),
        .qwords_to_send_synch(rx_qwords_to_send_synch),
        .trigger_tlp_ack(rx_trigger_tlp_ack),
        .rd_addr(rx_rd_addr), .rd_data(rx_rd_data),
        .committed_rd_address(rx_committed_rd_address),
        .host_tdata, .host_tvalid, .host_tlast, .host_tready);

endmodule

// ==== dv/naas_dma_tb.sv ====
`timescale 1ns/1ns
/* Frames are rebuilt from the host stream by descriptor. Only bytes covered by
   tstrb are compared on the last beat of a frame. */
module naas_dma_tb;

    localparam int N_TESTS        = 5;
    localparam int MAX_ROW_FRAMES = 8;
    localparam int READY_ALWAYS   = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_HOLD     = 2;
    localparam int READY_LIMIT    = 5000;     // MAC cycles per beat
    localparam int COLLECT_LIMIT  = 20000;    // trn cycles per test

    // ------------------------------------------------------------------------
    // Stimulus table with one row per test
    // ------------------------------------------------------------------------
    string row_name [N_TESTS] = '{"single 4-byte frame", "mixed lengths",
                                  "random host_tready", "short frames, random ready",
                                  "host_tready held low"};
    int row_frames [N_TESTS] = '{1, 8, 8, 8, 5};
    int row_mode   [N_TESTS] = '{READY_ALWAYS, READY_ALWAYS, READY_RANDOM,
                                 READY_RANDOM, READY_HOLD};
    int row_hold   [N_TESTS] = '{0, 0, 0, 0, 300};   // trn cycles with ready low
    int row_len    [N_TESTS][MAX_ROW_FRAMES] = '{
        '{4, 0, 0, 0, 0, 0, 0, 0},
        '{1, 8, 9, 64, 100, 255, 256, 17},
        '{33, 200, 7, 128, 64, 1, 250, 96},
        '{2, 3, 5, 8, 12, 16, 24, 40},
        '{256, 256, 256, 256, 256, 0, 0, 0}};   // 165 entries overfill the buffer

    logic                            s_axis_aclk = 1'b0;
    logic                            trn_clk     = 1'b0;
    logic                            arst_n;
    logic [naas_dma_pkg::DATA_W-1:0] s_axis_tdata;
    logic [naas_dma_pkg::STRB_W-1:0] s_axis_tstrb;
    logic                            s_axis_tvalid;
    logic                            s_axis_tlast;
    logic                            s_axis_tready;
    logic [naas_dma_pkg::DATA_W-1:0] host_tdata;
    logic                            host_tvalid;
    logic                            host_tlast;
    logic                            host_tready;

    logic [naas_dma_pkg::DATA_W-1:0] rx_q [$];   // Host beats of current test
    int   ready_mode = READY_ALWAYS;
    int   hold_left  = 0;
    int   burst_len  = 0;
    int   low_run    = 0;
    logic full_seen  = 1'b0;
    logic timed_out  = 1'b0;
    int   err_cnt    = 0;
    int   tests_run  = 0;
    int   tests_ok   = 0;

    naas_dma i_naas_dma (
        .s_axis_aclk, .trn_clk, .arst_n, .s_axis_tdata, .s_axis_tstrb,
        .s_axis_tvalid, .s_axis_tlast, .s_axis_tready,
        .host_tdata, .host_tvalid, .host_tlast, .host_tready);

    always #5 s_axis_aclk = ~s_axis_aclk;        // 10 ns MAC clock

    always begin
        #3;                                      // trn_clk phase offset
        forever #5 trn_clk = ~trn_clk;
    end

    // Data word for frame f, beat b of test t
    function automatic logic [63:0] beat_pattern(input int t, input int f, input int b);
        return {8'(t), 8'(f), 16'(b), 16'(b * 37 + f * 11 + 7), 16'hc35a};
    endfunction

    function automatic int expected_qwords(input int t);
        int total;
        total = 0;
        for (int f = 0; f < row_frames[t]; f++)
            total += 1 + (row_len[t][f] + 7) / 8;  // Descriptor plus data
        return total;
    endfunction

    // ------------------------------------------------------------------------
    // Host side ready pattern, capture and burst framing
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h2b745f02));
        forever begin
            @(negedge trn_clk);
            case (ready_mode)
                READY_RANDOM: host_tready = (($urandom & 32'd1) == 32'd0);
                READY_HOLD: begin
                    host_tready = (hold_left == 0);
                    if (hold_left > 0)
                        hold_left--;
                end
                default: host_tready = 1'b1;
            endcase
            if (arst_n && host_tvalid && host_tready) begin   // Transfers on next posedge
                rx_q.push_back(host_tdata);
                burst_len++;
                if (host_tlast) begin
                    burst_len = 0;
                end else if (burst_len >= naas_dma_pkg::MAX_BURST_QWORDS) begin
                    $display("Fail at %0t ns: burst of %0d qwords without host_tlast",
                             $time, burst_len);
                    err_cnt++;
                end
            end
        end
    end

    // Runs of low tready longer than the post-frame gap mean a full buffer
    always @(negedge s_axis_aclk) begin
        if (arst_n && !s_axis_tready)
            low_run++;
        else
            low_run = 0;
        if (low_run >= 4)
            full_seen = 1'b1;
    end

    // ------------------------------------------------------------------------
    // MAC side driver
    // ------------------------------------------------------------------------
    task automatic drive_frames(input int t);
        int nq;
        int vb;
        int wait_cnt;
        for (int f = 0; f < row_frames[t] && !timed_out; f++) begin
            nq = (row_len[t][f] + 7) / 8;
            for (int b = 0; b < nq && !timed_out; b++) begin
                @(negedge s_axis_aclk);
                vb            = row_len[t][f] - 8 * b;
                s_axis_tvalid = 1'b1;
                s_axis_tdata  = beat_pattern(t, f, b);
                s_axis_tlast  = (b == nq - 1);
                s_axis_tstrb  = (vb >= 8) ? 8'hff : 8'((1 << vb) - 1);   // Contiguous
                wait_cnt = 0;
                while (!s_axis_tready && !timed_out) begin
                    @(negedge s_axis_aclk);
                    wait_cnt++;
                    if (wait_cnt > READY_LIMIT) begin
                        $display("Timeout: s_axis_tready stayed low for %0d cycles in test %0d",
                                 wait_cnt, t);
                        timed_out = 1'b1;
                        err_cnt++;
                    end
                end
            end
        end
        @(negedge s_axis_aclk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    task automatic wait_for_qwords(input int t, input int exp_cnt);
        int cnt;
        cnt = 0;
        while (rx_q.size() < exp_cnt && !timed_out) begin
            @(posedge trn_clk);
            cnt++;
            if (cnt > COLLECT_LIMIT) begin
                $display("Timeout: test %0d got only %0d of %0d qwords on the host port",
                         t, rx_q.size(), exp_cnt);
                timed_out = 1'b1;
                err_cnt++;
            end
        end
    endtask

    // Rebuild frames from descriptors and compare against the table
    task automatic check_frames(input int t);
        naas_dma_pkg::buf_entry_u entry;
        logic [63:0]              mask;
        int                       idx;
        int                       nq;
        int                       vb;
        idx = 0;
        for (int f = 0; f < row_frames[t]; f++) begin
            nq = (row_len[t][f] + 7) / 8;
            if (idx + nq + 1 > rx_q.size()) begin
                $display("Fail at %0t ns: test %0d frame %0d missing from host stream",
                         $time, t, f);
                err_cnt++;
                return;
            end
            entry = rx_q[idx];
            if (entry.desc.byte_count != 16'(row_len[t][f]) || entry.desc.reserved != '0) begin
                $display("Fail at %0t ns: test %0d frame %0d desc %h, expected byte_count %0d",
                         $time, t, f, entry.data, row_len[t][f]);
                err_cnt++;
            end
            idx++;
            for (int b = 0; b < nq; b++) begin
                entry = rx_q[idx];
                vb    = row_len[t][f] - 8 * b;
                mask  = (vb >= 8) ? {64{1'b1}} : ((64'd1 << (8 * vb)) - 64'd1);
                if ((entry.data & mask) != (beat_pattern(t, f, b) & mask)) begin
                    $display("Fail at %0t ns: test %0d frame %0d qword %0d got %h expected %h",
                             $time, t, f, b, entry.data & mask, beat_pattern(t, f, b) & mask);
                    err_cnt++;
                end
                idx++;
            end
        end
        if (idx != rx_q.size()) begin
            $display("Fail at %0t ns: test %0d has %0d extra qwords", $time, t,
                     rx_q.size() - idx);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int err_before;
        arst_n        = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tstrb  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        host_tready   = 1'b0;
        repeat (10) @(negedge s_axis_aclk);
        arst_n = 1'b1;
        repeat (3) @(negedge s_axis_aclk);

        err_before = err_cnt;
        if (host_tvalid !== 1'b0 || s_axis_tready !== 1'b1) begin
            $display("Fail at %0t ns: after reset host_tvalid %b s_axis_tready %b",
                     $time, host_tvalid, s_axis_tready);
            err_cnt++;
        end
        tests_run++;
        if (err_cnt == err_before)
            tests_ok++;
        $display("test reset state: %s", (err_cnt == err_before) ? "passed" : "failed");

        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            err_before = err_cnt;
            rx_q.delete();
            full_seen  = 1'b0;
            hold_left  = row_hold[t];
            ready_mode = row_mode[t];
            drive_frames(t);
            wait_for_qwords(t, expected_qwords(t));
            if (!timed_out) begin
                repeat (40) @(posedge trn_clk);        // Catch any stray beats
                check_frames(t);
                if (burst_len != 0) begin
                    $display("Fail at %0t ns: test %0d left a burst open without host_tlast",
                             $time, t);
                    err_cnt++;
                end
                if (row_mode[t] == READY_HOLD && !full_seen) begin
                    $display("Fail at %0t ns: test %0d never saw s_axis_tready held low",
                             $time, t);
                    err_cnt++;
                end
            end
            tests_run++;
            if (err_cnt == err_before)
                tests_ok++;
            $display("test %0d %s: %s, %0d frames, %0d qwords", t, row_name[t],
                     (err_cnt == err_before) ? "passed" : "failed",
                     row_frames[t], rx_q.size());
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, err_cnt);
        if (err_cnt == 0 && !timed_out && tests_run == N_TESTS + 1)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
design/naas_dma_pkg.sv
design/rx_buffer.sv
design/rx_mac_interface.sv
design/rx_rd_addr_synch.sv
design/rx_tlp_trigger.sv
design/rx_trigger_synch.sv
design/rx_tlp_sender.sv
design/naas_dma.sv
dv/naas_dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the naas_dma testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module naas_dma_tb

out=$(./obj_dir/Vnaas_dma_tb)
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -q "RESULT: PASS"
